// File: build.f
+incdir+hdl
hdl/lsq_pkg.sv
hdl/lsq_if.sv
hdl/store_queue.sv
hdl/forward_select.sv
hdl/store_commit.sv
hdl/lsq_top.sv
bench/lsq_checker.sv
bench/lsq_tb.sv

// File: Makefile
# Verilator build and run of the store queue testbench
# any variable can be overridden, e.g. make test LOG=run2.log

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if $(LOG) holds the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/lsq_tb.sv
`timescale 1ns/1ps
`include "lsq_config.svh"

module lsq_tb;
	import lsq_pkg::*;

	localparam int N = `SQ_SIZE;
	localparam int STIM_CYCLES = 600; // upper bound on the cycles all tests take
	localparam addr_t X = 32'h200; // forwarding test addresses
	localparam addr_t Y = 32'h208;

	logic clock, reset;
	logic dispatch_en, dispatch_addr_ready, dispatch_data_ready;
	logic ex_en, ex_addr_en, ex_data_en, rt_en, rd_en, wb_ack;
	addr_t dispatch_addr, ex_addr, addr_rd, wb_adr;
	data_t dispatch_data, ex_data, fwd_data, wb_dat_w;
	sq_idx_t ex_index, ld_pos, tail_out;
	logic full, fwd_hit, fwd_valid, wb_cyc, wb_stb, wb_we;

	// reference ring
	addr_t m_addr [N];
	data_t m_data [N];
	logic m_arv [N]; // address ready
	logic m_drv [N]; // data ready
	int m_head, m_rt, m_tail;
	addr_t exp_adr [$]; // retired stores still owed to the bus, oldest first
	data_t exp_dat [$];

	// wishbone slave state
	logic bus_prev, pop_due, in_cycle, saw_full;
	addr_t adr_prev;
	data_t dat_prev;
	int wait_left, slow, writes, errors, base;

	lsq_top dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// stimulus cycles times 8 ns, times 8 for slack
	initial begin
		#(STIM_CYCLES * 8 * 8);
		$display("timeout: tests did not finish within %0d ns", STIM_CYCLES * 64);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
		assert (act === exp)
		else begin
			errors++;
			$display("ERROR %0t %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	function automatic logic model_full();
		return (m_tail + 1) % N == m_head; // one slot stays empty
	endfunction

	// one clock, model follows the edge, then the slave answers 1 ns later
	task automatic tick();
		logic was_full;
		@(posedge clock);
		#1;
		was_full = model_full(); // registered full gates this edge's dispatch
		if (pop_due)
			m_head = (m_head + 1) % N; // head frees one edge after the ack
		pop_due = bus_prev && wb_ack;
		if (pop_due) begin
			writes++;
			in_cycle = 1'b0;
			if (exp_adr.size() == 0) begin
				errors++;
				$display("bus write at %0t while no retired store was waiting", $time);
			end else begin
				compare("wb_adr", adr_prev, exp_adr.pop_front());
				compare("wb_dat_w", dat_prev, exp_dat.pop_front());
			end
		end
		if (ex_en && ex_addr_en) begin
			m_addr[ex_index] = ex_addr;
			m_arv[ex_index] = 1'b1;
		end
		if (ex_en && ex_data_en) begin
			m_data[ex_index] = ex_data;
			m_drv[ex_index] = 1'b1;
		end
		if (rt_en) begin // value at retire is what must reach memory
			exp_adr.push_back(m_addr[m_rt]);
			exp_dat.push_back(m_data[m_rt]);
			m_rt = (m_rt + 1) % N;
		end
		if (dispatch_en && !was_full) begin
			m_addr[m_tail] = dispatch_addr;
			m_data[m_tail] = dispatch_data;
			m_arv[m_tail] = dispatch_addr_ready;
			m_drv[m_tail] = dispatch_data_ready;
			m_tail = (m_tail + 1) % N;
		end
		compare("tail_out", tail_out, m_tail);
		compare("full", full, model_full());
		saw_full = saw_full | full;
		{dispatch_en, ex_en, ex_addr_en, ex_data_en, rt_en, rd_en} = '0;
		bus_prev = wb_stb;
		adr_prev = wb_adr;
		dat_prev = wb_dat_w;
		wb_ack = 1'b0;
		if (wb_stb && !in_cycle) begin // new cycle, 0 to 3 waits plus slow
			in_cycle = 1'b1;
			wait_left = $urandom_range(3, 0) + slow;
		end
		if (wb_stb && wait_left == 0)
			wb_ack = 1'b1;
		else if (wb_stb)
			wait_left--;
	endtask

	task automatic store(input addr_t a, input logic ar, input logic dr);
		dispatch_en = 1'b1;
		dispatch_addr = a;
		dispatch_data = {$urandom, $urandom};
		dispatch_addr_ready = ar;
		dispatch_data_ready = dr;
		tick();
	endtask

	task automatic exec(input int idx, input logic ae, input addr_t a, input logic de);
		ex_en = 1'b1;
		ex_index = sq_idx_t'(idx);
		ex_addr_en = ae;
		ex_addr = a;
		ex_data_en = de;
		ex_data = {$urandom, $urandom};
		tick();
	endtask

	// youngest older ready address match between head and pos
	task automatic lookup(input logic en, input addr_t a, input int pos);
		logic h, v;
		data_t d;
		int s;
		tick();
		h = 1'b0;
		v = 1'b0;
		d = '0;
		for (int k = (pos - m_head + N) % N - 1; k >= 0; k--) begin
			s = (m_head + k) % N;
			if (en && !h && m_arv[s] && m_addr[s] == a) begin
				h = 1'b1;
				v = m_drv[s];
				d = m_data[s];
			end
		end
		rd_en = en;
		addr_rd = a;
		ld_pos = sq_idx_t'(pos);
		#1;
		compare("fwd_hit", fwd_hit, h);
		compare("fwd_valid", fwd_valid, v);
		if (v)
			compare("fwd_data", fwd_data, d);
	endtask

	task automatic retire_all();
		while (m_rt != m_tail) begin
			rt_en = 1'b1;
			tick();
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((exp_adr.size() != 0 || m_head != m_rt) && n < 300) begin
			tick();
			n++;
		end
		if (n == 300) begin
			errors++;
			$display("commit unit did not write out the retired stores");
		end
	endtask

	initial begin
		void'($urandom(65));
		reset = 1'b1;
		{dispatch_en, dispatch_addr_ready, dispatch_data_ready, ex_en, ex_addr_en} = '0;
		{ex_data_en, rt_en, rd_en, wb_ack, ex_index, ld_pos} = '0;
		{dispatch_addr, ex_addr, addr_rd, dispatch_data, ex_data} = '0;
		{m_head, m_rt, m_tail, wait_left, slow, writes, errors} = '0;
		{bus_prev, pop_due, in_cycle, saw_full} = '0;
		for (int i = 0; i < N; i++) begin
			m_arv[i] = 1'b0;
			m_drv[i] = 1'b0;
		end
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;

		// state right after reset, empty queue never hits
		compare("tail_out", tail_out, 0);
		compare("full", full, 0);
		compare("wb_cyc", wb_cyc, 0);
		lookup(1'b1, X, 0);
		lookup(1'b1, 32'h100, 5);

		// commit order, late address and data, data rewritten at execute
		for (int i = 0; i < 12; i++)
			store(32'h100 + 8 * ($urandom % 3), 1'($urandom), 1'($urandom));
		for (int i = 0; i < 12; i++) begin
			rt_en = 1'b1;
			exec(i, !m_arv[i], 32'h100 + 8 * ($urandom % 3), 1'b1);
		end
		drain();

		// forwarding over slots 12 to 1, across the wrap
		base = m_tail;
		store(X, 1'b1, 1'b1);
		store(Y, 1'b1, 1'b1);
		store(X, 1'b1, 1'b1);
		store(X, 1'b0, 1'b1); // address unknown, must be skipped
		store(X, 1'b1, 1'b0); // hit without valid
		store(X, 1'b1, 1'b1);
		for (int p = 0; p <= 6; p++) begin
			lookup(1'b1, X, (base + p) % N);
			lookup(1'b1, Y, (base + p) % N);
		end
		lookup(1'b0, X, m_tail);
		exec((base + 3) % N, 1'b1, X, 1'b0); // late address joins the candidates
		exec((base + 4) % N, 1'b0, X, 1'b1); // late data makes it valid
		for (int p = 0; p <= 6; p++)
			lookup(1'b1, X, (base + p) % N);
		retire_all();
		drain();

		// slow acks until the ring is full, dispatch kept high throughout
		slow = 6;
		for (int i = 0; i < 30; i++) begin
			rt_en = (m_rt != m_tail);
			store(32'h300 + 8 * i, 1'b1, 1'b1);
		end
		compare("full", saw_full, 1);
		slow = 0;
		retire_all();
		drain();
		for (int i = 0; i < 3; i++)
			store(32'h400 + 8 * i, 1'b1, 1'b1); // dispatch resumes
		retire_all();
		drain();

		$display("bench errors %0d, assertion failures %0d, bus writes %0d",
			errors, dut_i.chk_i.fail_count, writes);
		if (errors + dut_i.chk_i.fail_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: bench/lsq_checker.sv
`timescale 1ns/1ps

module lsq_checker (
	input logic clock,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic wb_ack,
	input lsq_pkg::addr_t wb_adr,
	input lsq_pkg::data_t wb_dat_w,
	input logic full,
	input lsq_pkg::sq_idx_t tail_out,
	input logic rd_en,
	input logic fwd_hit,
	input logic fwd_valid
);
	int fail_count = 0; // summed into the bench's closing line

	task automatic count_fail(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	// cyc and stb always move together in a classic cycle
	cyc_stb: assert property (@(posedge clock) disable iff (reset) wb_cyc == wb_stb)
		else count_fail("wb_cyc differs from wb_stb");
	only_writes: assert property (@(posedge clock) disable iff (reset) wb_stb |-> wb_we)
		else count_fail("bus cycle without wb_we");

	// master holds the request until the slave acks
	held: assert property (@(posedge clock) disable iff (reset)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_dat_w) && $stable(wb_we))
		else count_fail("bus request changed before ack");
	gap: assert property (@(posedge clock) disable iff (reset) wb_stb && wb_ack |=> !wb_cyc)
		else count_fail("no idle cycle after ack");
	idle_after_reset: assert property (@(posedge clock) reset |=> !wb_cyc)
		else count_fail("wb_cyc high right after reset");

	// a full ring refuses dispatch
	no_overrun: assert property (@(posedge clock) disable iff (reset) full |=> $stable(tail_out))
		else count_fail("tail_out moved while full");

	// lookup outputs stay quiet without a request
	quiet: assert property (@(posedge clock) disable iff (reset) !rd_en |-> !fwd_hit && !fwd_valid)
		else count_fail("forward result without rd_en");

endmodule

bind lsq_top lsq_checker chk_i (.*);

// File: hdl/lsq_top.sv
`timescale 1ns/1ps

module lsq_top (
	input logic clock,
	input logic reset,

	input logic dispatch_en,
	input logic dispatch_addr_ready,
	input logic dispatch_data_ready,
	input lsq_pkg::addr_t dispatch_addr,
	input lsq_pkg::data_t dispatch_data,

	input logic ex_en,
	input logic ex_addr_en,
	input logic ex_data_en,
	input lsq_pkg::sq_idx_t ex_index,
	input lsq_pkg::addr_t ex_addr,
	input lsq_pkg::data_t ex_data,

	input logic rt_en,

	input logic rd_en, // load lookup
	input lsq_pkg::addr_t addr_rd,
	input lsq_pkg::sq_idx_t ld_pos,

	input logic wb_ack,

	output lsq_pkg::sq_idx_t tail_out,
	output logic full,
	output logic fwd_hit,
	output logic fwd_valid,
	output lsq_pkg::data_t fwd_data,

	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lsq_pkg::addr_t wb_adr,
	output lsq_pkg::data_t wb_dat_w
);

	fwd_if fwd_bus ();
	commit_if cmt_bus ();

	// lookup client side comes straight from the ports
	assign fwd_bus.rd_en = rd_en;
	assign fwd_bus.addr_rd = addr_rd;
	assign fwd_bus.ld_pos = ld_pos;
	assign fwd_hit = fwd_bus.hit;
	assign fwd_valid = fwd_bus.valid;
	assign fwd_data = fwd_bus.data_rd;

	store_queue queue_i (
		.clock(clock),
		.reset(reset),
		.dispatch_en(dispatch_en),
		.dispatch_addr_ready(dispatch_addr_ready),
		.dispatch_data_ready(dispatch_data_ready),
		.dispatch_addr(dispatch_addr),
		.dispatch_data(dispatch_data),
		.ex_en(ex_en),
		.ex_addr_en(ex_addr_en),
		.ex_data_en(ex_data_en),
		.ex_index(ex_index),
		.ex_addr(ex_addr),
		.ex_data(ex_data),
		.rt_en(rt_en),
		.fq(fwd_bus),
		.cq(cmt_bus),
		.tail_out(tail_out),
		.full(full)
	);

	forward_select select_i (
		.sel(fwd_bus),
		.q(fwd_bus)
	);

	store_commit commit_i (
		.clock(clock),
		.reset(reset),
		.cq(cmt_bus),
		.wb_ack(wb_ack),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w)
	);

endmodule

// File: hdl/store_commit.sv
`timescale 1ns/1ps

module store_commit (
	input logic clock,
	input logic reset,
	commit_if.commit cq, // head store of the queue
	input logic wb_ack,

	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output lsq_pkg::addr_t wb_adr,
	output lsq_pkg::data_t wb_dat_w
);
	import lsq_pkg::*;

	commit_state_t state, state_n;
	addr_t adr_q; // captured head address, held through the cycle
	data_t dat_q; // captured head data

	always_comb begin
		state_n = state;
		case (state)
			idle: if (cq.pending) state_n = bus; // open a bus cycle
			bus: if (wb_ack) state_n = done; // write accepted
			done: state_n = idle; // head moves on this cycle
			default: state_n = idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= idle;
		else
			state <= state_n;
	end

	// latch the store on leaving idle
	always_ff @(posedge clock) begin
		if (state == idle && cq.pending) begin
			adr_q <= cq.head_addr;
			dat_q <= cq.head_data;
		end
	end

	// classic single write, cyc and stb move together
	assign wb_cyc = (state == bus);
	assign wb_stb = (state == bus);
	assign wb_we = (state == bus); // every cycle is a write
	assign wb_adr = adr_q;
	assign wb_dat_w = dat_q;

	// one cycle pulse after the ack edge, also the idle gap on the bus
	assign cq.pop = (state == done);

endmodule

// File: hdl/forward_select.sv
`timescale 1ns/1ps
`include "lsq_config.svh"

module forward_select (
	fwd_if.select sel, // lookup request and result
	fwd_if.queue q // queue entries, head and tail
);
	import lsq_pkg::*;

	logic [`SQ_SIZE-1:0] cand; // matching older stores by slot
	logic [`SQ_SIZE-1:0] rot; // cand rotated so bit 0 is head
	logic [`SQ_SIZE-1:0] gnt; // rotated one hot youngest candidate
	sq_idx_t lim; // distance head to ld_pos
	sq_idx_t occ; // distance head to tail
	sq_idx_t pick; // encoded rotated position
	sq_idx_t sel_idx; // ring slot of the chosen store

	assign lim = sel.ld_pos - q.head;
	assign occ = q.tail - q.head;

	always_comb begin
		sq_idx_t off;
		logic found;
		cand = '0;
		rot = '0;
		gnt = '0;
		pick = '0;
		found = 1'b0;
		for (int i = 0; i < `SQ_SIZE; i++) begin
			off = sq_idx_t'(i) - q.head; // age of slot i where 0 is oldest
			cand[i] = sel.rd_en && (off < lim) && (off < occ)
				&& q.sq_addr_rdy[i] && (q.sq_addr[i] == sel.addr_rd);
		end
		for (int k = 0; k < `SQ_SIZE; k++)
			rot[k] = cand[sq_idx_t'(q.head + sq_idx_t'(k))]; // unwrap the ring
		for (int k = `SQ_SIZE - 1; k >= 0; k--) begin
			if (rot[k] && !found) begin // highest bit is closest to ld_pos
				gnt[k] = 1'b1;
				found = 1'b1;
			end
		end
		for (int k = 0; k < `SQ_SIZE; k++)
			if (gnt[k])
				pick = pick | sq_idx_t'(k);
	end

	assign sel_idx = q.head + pick; // back to a ring index
	assign sel.hit = |cand; // already gated by rd_en
	assign sel.valid = sel.hit && q.sq_data_rdy[sel_idx];
	assign sel.data_rd = q.sq_data[sel_idx];

endmodule

// File: hdl/store_queue.sv
`timescale 1ns/1ps
`include "lsq_config.svh"

module store_queue (
	input logic clock,
	input logic reset,

	input logic dispatch_en, // new store in program order
	input logic dispatch_addr_ready, // address already known at dispatch
	input logic dispatch_data_ready, // data already known at dispatch
	input lsq_pkg::addr_t dispatch_addr,
	input lsq_pkg::data_t dispatch_data,

	input logic ex_en, // store executes
	input logic ex_addr_en, // execute supplies the address
	input logic ex_data_en, // execute supplies the data
	input lsq_pkg::sq_idx_t ex_index, // slot of the executing store
	input lsq_pkg::addr_t ex_addr,
	input lsq_pkg::data_t ex_data,

	input logic rt_en, // oldest unretired store retires

	fwd_if.queue fq, // entry state out to the forwarding selector
	commit_if.queue cq, // head store out to the commit unit

	output lsq_pkg::sq_idx_t tail_out, // slot the next dispatch gets
	output logic full
);
	import lsq_pkg::*;

	// entry payload, no reset needed
	addr_t [`SQ_SIZE-1:0] addr_q, addr_n;
	data_t [`SQ_SIZE-1:0] data_q, data_n;

	// per entry ready bits
	logic [`SQ_SIZE-1:0] addr_rdy_q, addr_rdy_n;
	logic [`SQ_SIZE-1:0] data_rdy_q, data_rdy_n;

	// ring pointers, head <= rt_ptr <= tail in ring order
	sq_idx_t head, head_n;
	sq_idx_t rt_ptr, rt_ptr_n; // first store not yet retired
	sq_idx_t tail, tail_n;

	// one slot kept empty so full and empty differ
	assign full = (sq_idx_t'(tail + 1'b1) == head);
	assign tail_out = tail;

	always_comb begin
		addr_n = addr_q;
		data_n = data_q;
		addr_rdy_n = addr_rdy_q;
		data_rdy_n = data_rdy_q;
		head_n = head;
		rt_ptr_n = rt_ptr;
		tail_n = tail;

		// commit finished with the head store
		if (cq.pop) begin
			addr_rdy_n[head] = 1'b0;
			data_rdy_n[head] = 1'b0;
			head_n = head + 1'b1;
		end

		// late address and data from execute
		if (ex_en) begin
			if (ex_addr_en) begin
				addr_n[ex_index] = ex_addr;
				addr_rdy_n[ex_index] = 1'b1;
			end
			if (ex_data_en) begin
				data_n[ex_index] = ex_data;
				data_rdy_n[ex_index] = 1'b1;
			end
		end

		// in order retire, the environment never retires past tail
		if (rt_en)
			rt_ptr_n = rt_ptr + 1'b1;

		// registered full decides, a same cycle pop does not help dispatch
		if (dispatch_en && !full) begin
			addr_n[tail] = dispatch_addr;
			data_n[tail] = dispatch_data;
			addr_rdy_n[tail] = dispatch_addr_ready;
			data_rdy_n[tail] = dispatch_data_ready;
			tail_n = tail + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			rt_ptr <= '0;
			tail <= '0;
			addr_rdy_q <= '0;
			data_rdy_q <= '0;
		end else begin
			head <= head_n;
			rt_ptr <= rt_ptr_n;
			tail <= tail_n;
			addr_rdy_q <= addr_rdy_n;
			data_rdy_q <= data_rdy_n;
		end
	end

	always_ff @(posedge clock) begin
		addr_q <= addr_n;
		data_q <= data_n;
	end

	// registered state only, the selector never sees next state values
	assign fq.sq_addr = addr_q;
	assign fq.sq_addr_rdy = addr_rdy_q;
	assign fq.sq_data = data_q;
	assign fq.sq_data_rdy = data_rdy_q;
	assign fq.head = head;
	assign fq.tail = tail;

	assign cq.pending = (head != rt_ptr); // retired but not yet in memory
	assign cq.head_addr = addr_q[head];
	assign cq.head_data = data_q[head];

endmodule

// File: hdl/lsq_if.sv
`timescale 1ns/1ps
`include "lsq_config.svh"

// load lookup into the store queue, plus the queue state the selector reads
interface fwd_if;
	import lsq_pkg::*;

	logic rd_en; // lookup request
	addr_t addr_rd; // load address
	sq_idx_t ld_pos; // sq tail seen by the load at dispatch
	logic hit; // some older store matches
	logic valid; // matching store has its data
	data_t data_rd; // forwarded data

	addr_t [`SQ_SIZE-1:0] sq_addr; // entry addresses
	logic [`SQ_SIZE-1:0] sq_addr_rdy; // address known
	data_t [`SQ_SIZE-1:0] sq_data; // entry data
	logic [`SQ_SIZE-1:0] sq_data_rdy; // data known
	sq_idx_t head; // oldest store not yet written to memory
	sq_idx_t tail; // next free slot

	modport client (output rd_en, addr_rd, ld_pos, input hit, valid, data_rd);
	modport select (input rd_en, addr_rd, ld_pos, output hit, valid, data_rd);
	modport queue (output sq_addr, sq_addr_rdy, sq_data, sq_data_rdy, head, tail);
endinterface

// oldest retired store handed to the commit unit
interface commit_if;
	import lsq_pkg::*;

	logic pending; // a retired store sits at head
	addr_t head_addr;
	data_t head_data;
	logic pop; // head has been written, free it

	modport queue (output pending, head_addr, head_data, input pop);
	modport commit (input pending, head_addr, head_data, output pop);
endinterface

// File: hdl/lsq_pkg.sv
`include "lsq_config.svh"

package lsq_pkg;

	// ring position, shared by head, tail, ld_pos and ex_index
	typedef logic [$clog2(`SQ_SIZE)-1:0] sq_idx_t;

	typedef logic [`ADDR_W-1:0] addr_t; // memory address
	typedef logic [`DATA_W-1:0] data_t; // store payload

	// commit unit states
	typedef enum logic [1:0] {
		idle, // waiting for a retired store
		bus,  // wishbone cycle open, waiting for ack
		done  // ack seen, pop the head this cycle
	} commit_state_t;

endpackage

// File: hdl/lsq_config.svh
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// store queue ring depth, must be a power of two so the index wraps for free
`define SQ_SIZE 16

// one slot stays empty, usable capacity is SQ_SIZE-1

`define ADDR_W 32 // byte address of a store or load
`define DATA_W 64 // full word stores only

`endif
